/* rtl/soc_pkg.sv */
package soc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8; // one strobe per byte lane
    localparam int OFS_WIDTH  = 4;              // register offset bits seen by the slaves

    // address map, top nibble picks the region
    localparam logic [ADDR_WIDTH-1:0] REGION_MASK = 32'hF000_0000;
    localparam logic [ADDR_WIDTH-1:0] MEM_BASE    = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] TIMER_BASE  = 32'h1000_0000;
    localparam logic [ADDR_WIDTH-1:0] PLIC_BASE   = 32'h2000_0000;

    localparam int MEM_WORDS = 256;

    // timer block registers
    localparam logic [OFS_WIDTH-1:0] TMR0_CMP_OFS  = 4'h0;
    localparam logic [OFS_WIDTH-1:0] TMR0_CTRL_OFS = 4'h4; // bit0 enable, bit1 flag (w1c)
    localparam logic [OFS_WIDTH-1:0] TMR1_CMP_OFS  = 4'h8;
    localparam logic [OFS_WIDTH-1:0] TMR1_CTRL_OFS = 4'hC;

    // plic registers
    localparam logic [OFS_WIDTH-1:0] PLIC_ENABLE_OFS  = 4'h0;
    localparam logic [OFS_WIDTH-1:0] PLIC_PENDING_OFS = 4'h4; // read only
    localparam logic [OFS_WIDTH-1:0] PLIC_CLAIM_OFS   = 4'h8; // read only, 0 = nothing

    // interrupt sources, line 0 stays reserved
    localparam int NUM_IRQ_LINES = 8;
    localparam int IRQ_TIMER0    = 2;
    localparam int IRQ_TIMER1    = 3;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_DECERR = 2'd3
    } resp_t;

    typedef enum logic [1:0] {
        SEL_MEM,
        SEL_TMR,
        SEL_PLIC,
        SEL_NONE    // unmapped region
    } slave_sel_t;

endpackage : soc_pkg

/* rtl/soc_bus_if.sv */
`timescale 1ns/10ps

// one controller to slave link, fixed latency
// sel is a single cycle strobe, rdata follows one cycle later
interface soc_bus_if;

    logic                            sel;    // one cycle per access
    logic                            write;
    logic [soc_pkg::ADDR_WIDTH-1:0]  addr;
    logic [soc_pkg::DATA_WIDTH-1:0]  wdata;
    logic [soc_pkg::STRB_WIDTH-1:0]  wstrb;
    logic [soc_pkg::DATA_WIDTH-1:0]  rdata;  // registered in the slave

    // bus controller side
    modport ctrl (
        output sel,
        output write,
        output addr,
        output wdata,
        output wstrb,
        input  rdata
    );

    // slave side, never stalls so no ready
    modport slave (
        input  sel,
        input  write,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata
    );

endinterface : soc_bus_if

/* rtl/bus_ctrl.sv */
`timescale 1ns/10ps

module bus_ctrl (
    input  logic                            clk_i,
    input  logic                            reset_i,

    input  logic                            req_valid_i,
    output logic                            req_ready_o,
    input  logic                            req_write_i,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  req_addr_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  req_wdata_i,
    input  logic [soc_pkg::STRB_WIDTH-1:0]  req_wstrb_i,

    output logic                            rsp_valid_o,
    input  logic                            rsp_ready_i,
    output logic [soc_pkg::DATA_WIDTH-1:0]  rsp_rdata_o,
    output soc_pkg::resp_t                  rsp_resp_o,

    soc_bus_if.ctrl                         mem_o,
    soc_bus_if.ctrl                         tmr_o,
    soc_bus_if.ctrl                         plic_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,   // slave select cycle
        ST_RESPOND   // hold response until host takes it
    } state_t;

    state_t                         state_q;
    soc_pkg::slave_sel_t            sel_q, dec_sel;
    logic                           write_q;
    logic [soc_pkg::ADDR_WIDTH-1:0] addr_q;
    logic [soc_pkg::DATA_WIDTH-1:0] wdata_q;
    logic [soc_pkg::STRB_WIDTH-1:0] wstrb_q;

    ////////////////////////////////////////////////////////////////////////////
    // region decode on the incoming address
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req_addr_i & soc_pkg::REGION_MASK)
            soc_pkg::MEM_BASE:   dec_sel = soc_pkg::SEL_MEM;
            soc_pkg::TIMER_BASE: dec_sel = soc_pkg::SEL_TMR;
            soc_pkg::PLIC_BASE:  dec_sel = soc_pkg::SEL_PLIC;
            default:             dec_sel = soc_pkg::SEL_NONE;
        endcase
    end

    // one transaction in flight
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            sel_q   <= soc_pkg::SEL_NONE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        sel_q   <= dec_sel;
                        // unmapped goes straight to the error response
                        state_q <= (dec_sel == soc_pkg::SEL_NONE) ? ST_RESPOND : ST_ACCESS;
                    end
                end
                ST_ACCESS:  state_q <= ST_RESPOND; // slave rdata valid next cycle
                ST_RESPOND: if (rsp_ready_i) state_q <= ST_IDLE;
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    // request payload, loaded on accept only
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            write_q <= req_write_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
            wstrb_q <= req_wstrb_i;
        end
    end

    assign req_ready_o = (state_q == ST_IDLE);
    assign rsp_valid_o = (state_q == ST_RESPOND);

    ////////////////////////////////////////////////////////////////////////////
    // slave links, shared payload and one-hot select
    ////////////////////////////////////////////////////////////////////////////

    assign mem_o.sel  = (state_q == ST_ACCESS) && (sel_q == soc_pkg::SEL_MEM);
    assign tmr_o.sel  = (state_q == ST_ACCESS) && (sel_q == soc_pkg::SEL_TMR);
    assign plic_o.sel = (state_q == ST_ACCESS) && (sel_q == soc_pkg::SEL_PLIC);

    assign mem_o.write  = write_q;
    assign mem_o.addr   = addr_q;
    assign mem_o.wdata  = wdata_q;
    assign mem_o.wstrb  = wstrb_q;
    assign tmr_o.write  = write_q;
    assign tmr_o.addr   = addr_q;
    assign tmr_o.wdata  = wdata_q;
    assign tmr_o.wstrb  = wstrb_q;
    assign plic_o.write = write_q;
    assign plic_o.addr  = addr_q;
    assign plic_o.wdata = wdata_q;
    assign plic_o.wstrb = wstrb_q;

    // held response, slaves keep rdata until their next read so it stays stable
    always_comb begin
        case (sel_q)
            soc_pkg::SEL_MEM:  rsp_rdata_o = mem_o.rdata;
            soc_pkg::SEL_TMR:  rsp_rdata_o = tmr_o.rdata;
            soc_pkg::SEL_PLIC: rsp_rdata_o = plic_o.rdata;
            default:           rsp_rdata_o = '0;  // decode error
        endcase
        if (write_q) rsp_rdata_o = '0;           // writes answer with zero
    end

    assign rsp_resp_o = (sel_q == soc_pkg::SEL_NONE) ? soc_pkg::RESP_DECERR
                                                     : soc_pkg::RESP_OKAY;

endmodule : bus_ctrl

/* rtl/main_memory.sv */
`timescale 1ns/10ps

// word memory slave, single port
module main_memory (
    input  logic      clk_i,
    soc_bus_if.slave  bus_s
);

    logic [soc_pkg::DATA_WIDTH-1:0] mem [soc_pkg::MEM_WORDS];
    logic [$clog2(soc_pkg::MEM_WORDS)-1:0] word_idx;

    // byte address -> word index, upper bits alias
    assign word_idx = bus_s.addr[$clog2(soc_pkg::MEM_WORDS)+1:2];

    ////////////////////////////////////////////////////////////////////////////
    // write port with byte lanes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (bus_s.sel && bus_s.write) begin
            for (int b = 0; b < soc_pkg::STRB_WIDTH; b++) begin
                if (bus_s.wstrb[b]) begin
                    mem[word_idx][8*b +: 8] <= bus_s.wdata[8*b +: 8];
                end
            end
        end
    end

    // read data registered, shows up the cycle after sel
    // and holds until the next read
    always_ff @(posedge clk_i) begin
        if (bus_s.sel && !bus_s.write) begin
            bus_s.rdata <= mem[word_idx];
        end
    end

endmodule : main_memory

/* rtl/timer_bank.sv */
`timescale 1ns/10ps

module timer_bank (
    input  logic       clk_i,
    input  logic       reset_i,
    soc_bus_if.slave   bus_s,
    output logic [1:0] irq_o
);

    logic [soc_pkg::DATA_WIDTH-1:0] cmp_q [2];
    logic [soc_pkg::DATA_WIDTH-1:0] cnt_q [2]; // not visible on the bus
    logic [1:0]                     en_q, flag_q;
    logic [1:0]                     cmp_we, ctrl_we;
    logic [soc_pkg::OFS_WIDTH-1:0]  ofs;
    logic [soc_pkg::DATA_WIDTH-1:0] rd_next;
    logic                           wr;

    assign ofs = bus_s.addr[soc_pkg::OFS_WIDTH-1:0];
    assign wr  = bus_s.sel && bus_s.write;

    // register write decode
    assign cmp_we[0]  = wr && (ofs == soc_pkg::TMR0_CMP_OFS);
    assign cmp_we[1]  = wr && (ofs == soc_pkg::TMR1_CMP_OFS);
    assign ctrl_we[0] = wr && (ofs == soc_pkg::TMR0_CTRL_OFS);
    assign ctrl_we[1] = wr && (ofs == soc_pkg::TMR1_CTRL_OFS);

    ////////////////////////////////////////////////////////////////////////////
    // counters and flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 2; i++) begin
                cmp_q[i] <= '0;
                cnt_q[i] <= '0;
            end
            en_q   <= '0;  // timers start disabled
            flag_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (en_q[i] && !flag_q[i]) begin
                    if (cnt_q[i] == cmp_q[i]) flag_q[i] <= 1'b1; // hit, counter parks
                    else                      cnt_q[i]  <= cnt_q[i] + 1'b1;
                end
                if (cmp_we[i]) cmp_q[i] <= bus_s.wdata;
                if (ctrl_we[i]) begin
                    en_q[i] <= bus_s.wdata[0];
                    if (bus_s.wdata[1]) begin  // w1c: flag and counter back to zero
                        flag_q[i] <= 1'b0;
                        cnt_q[i]  <= '0;
                    end
                end
            end
        end
    end

    // readback mux
    always_comb begin
        rd_next = '0;
        case (ofs)
            soc_pkg::TMR0_CMP_OFS:  rd_next = cmp_q[0];
            soc_pkg::TMR1_CMP_OFS:  rd_next = cmp_q[1];
            soc_pkg::TMR0_CTRL_OFS: rd_next[1:0] = {flag_q[0], en_q[0]};
            soc_pkg::TMR1_CTRL_OFS: rd_next[1:0] = {flag_q[1], en_q[1]};
            default:                rd_next = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (bus_s.sel && !bus_s.write) bus_s.rdata <= rd_next;
    end

    assign irq_o = flag_q; // flag level is the line

endmodule : timer_bank

/* rtl/plic.sv */
`timescale 1ns/10ps

module plic (
    input  logic       clk_i,
    input  logic       reset_i,
    soc_bus_if.slave   bus_s,
    input  logic [1:0] src_i,  // timer 0, timer 1
    output logic       irq_o
);

    logic [soc_pkg::NUM_IRQ_LINES-1:0]         src, enable_q, active;
    logic [$clog2(soc_pkg::NUM_IRQ_LINES)-1:0] claim_id;
    logic [soc_pkg::OFS_WIDTH-1:0]             ofs;
    logic [soc_pkg::DATA_WIDTH-1:0]            rd_next;

    assign ofs = bus_s.addr[soc_pkg::OFS_WIDTH-1:0];

    // source vector, unused lines tied low
    always_comb begin
        src = '0;
        src[soc_pkg::IRQ_TIMER0] = src_i[0];
        src[soc_pkg::IRQ_TIMER1] = src_i[1];
    end

    always_ff @(posedge clk_i) begin
        if (reset_i)                                                  enable_q <= '0;
        else if (bus_s.sel && bus_s.write && ofs == soc_pkg::PLIC_ENABLE_OFS)
            enable_q <= bus_s.wdata[soc_pkg::NUM_IRQ_LINES-1:0];
    end

    assign active = src & enable_q;
    assign irq_o  = |active;   // combinational, no sync stage

    ////////////////////////////////////////////////////////////////////////////
    // claim, lowest enabled pending line wins
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        claim_id = '0;
        for (int i = soc_pkg::NUM_IRQ_LINES - 1; i > 0; i--) begin  // line 0 reserved
            if (active[i]) claim_id = i[$clog2(soc_pkg::NUM_IRQ_LINES)-1:0];
        end
    end

    always_comb begin
        rd_next = '0;
        case (ofs)
            soc_pkg::PLIC_ENABLE_OFS:  rd_next[soc_pkg::NUM_IRQ_LINES-1:0] = enable_q;
            soc_pkg::PLIC_PENDING_OFS: rd_next[soc_pkg::NUM_IRQ_LINES-1:0] = src;
            soc_pkg::PLIC_CLAIM_OFS:   rd_next[$clog2(soc_pkg::NUM_IRQ_LINES)-1:0] = claim_id;
            default:                   rd_next = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (bus_s.sel && !bus_s.write) bus_s.rdata <= rd_next; // sampled on sel
    end

endmodule : plic

/* rtl/soc_top.sv */
`timescale 1ns/10ps

module soc_top (
    input  logic                            sys_clock_i,
    input  logic                            reset_i,

    // host request channel
    input  logic                            req_valid_i,
    output logic                            req_ready_o,
    input  logic                            req_write_i,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]  req_addr_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]  req_wdata_i,
    input  logic [soc_pkg::STRB_WIDTH-1:0]  req_wstrb_i,

    // host response channel
    output logic                            rsp_valid_o,
    input  logic                            rsp_ready_i,
    output logic [soc_pkg::DATA_WIDTH-1:0]  rsp_rdata_o,
    output soc_pkg::resp_t                  rsp_resp_o,

    // external interrupt, was line 11 of the core socket
    output logic                            irq_o
);

    ////////////////////////////////////////////////////////////////////////////
    // slave links
    ////////////////////////////////////////////////////////////////////////////

    soc_bus_if mem_bus  ();
    soc_bus_if tmr_bus  ();
    soc_bus_if plic_bus ();

    logic [1:0] tmr_irq; // timer flags -> plic sources 2 and 3

    ////////////////////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////////////////////

    bus_ctrl bus_ctrl_u (
        .clk_i       ( sys_clock_i ),
        .reset_i     ( reset_i     ),
        .req_valid_i ( req_valid_i ),
        .req_ready_o ( req_ready_o ),
        .req_write_i ( req_write_i ),
        .req_addr_i  ( req_addr_i  ),
        .req_wdata_i ( req_wdata_i ),
        .req_wstrb_i ( req_wstrb_i ),
        .rsp_valid_o ( rsp_valid_o ),
        .rsp_ready_i ( rsp_ready_i ),
        .rsp_rdata_o ( rsp_rdata_o ),
        .rsp_resp_o  ( rsp_resp_o  ),
        .mem_o       ( mem_bus     ),
        .tmr_o       ( tmr_bus     ),
        .plic_o      ( plic_bus    )
    );

    main_memory main_memory_u (
        .clk_i ( sys_clock_i ),
        .bus_s ( mem_bus     )
    );

    timer_bank timer_bank_u (
        .clk_i   ( sys_clock_i ),
        .reset_i ( reset_i     ),
        .bus_s   ( tmr_bus     ),
        .irq_o   ( tmr_irq     )  // level, one per timer
    );

    plic plic_u (
        .clk_i   ( sys_clock_i ),
        .reset_i ( reset_i     ),
        .bus_s   ( plic_bus    ),
        .src_i   ( tmr_irq     ),
        .irq_o   ( irq_o       )
    );

endmodule : soc_top

/* test/soc_checker.sv */
`timescale 1ns/10ps

// host handshake properties, bound into bus_ctrl
module soc_checker (
    input logic                            clk_i,
    input logic                            reset_i,
    input logic                            req_valid_i,
    input logic                            req_ready_i,
    input logic                            req_write_i,
    input logic [soc_pkg::ADDR_WIDTH-1:0]  req_addr_i,
    input logic [soc_pkg::DATA_WIDTH-1:0]  req_wdata_i,
    input logic [soc_pkg::STRB_WIDTH-1:0]  req_wstrb_i,
    input logic                            rsp_valid_i,
    input logic                            rsp_ready_i,
    input logic [soc_pkg::DATA_WIDTH-1:0]  rsp_rdata_i,
    input soc_pkg::resp_t                  rsp_resp_i,
    input logic [2:0]                      sel_i       // mem, tmr, plic
);

    int fail_count = 0; // summed into the closing line

    // request held steady until accepted
    req_held: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i && !req_ready_i |=> req_valid_i
            && $stable({req_write_i, req_addr_i, req_wdata_i, req_wstrb_i}))
        else begin
            fail_count++;
            $error("request dropped or changed before it was accepted");
        end

    // response frozen under back-pressure
    rsp_held: assert property (@(posedge clk_i) disable iff (reset_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i
            && $stable(rsp_rdata_i) && $stable(rsp_resp_i))
        else begin
            fail_count++;
            $error("response dropped or changed while the host stalled");
        end

    sel_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(sel_i))
        else begin
            fail_count++;
            $error("more than one slave selected");
        end

    // one transaction in flight
    no_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
        !(rsp_valid_i && req_ready_i))
        else begin
            fail_count++;
            $error("request channel ready while a response is pending");
        end

endmodule : soc_checker

bind bus_ctrl soc_checker handshake_chk (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .req_valid_i ( req_valid_i ),
    .req_ready_i ( req_ready_o ),
    .req_write_i ( req_write_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_wstrb_i ( req_wstrb_i ),
    .rsp_valid_i ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_rdata_i ( rsp_rdata_o ),
    .rsp_resp_i  ( rsp_resp_o  ),
    .sel_i       ( {mem_o.sel, tmr_o.sel, plic_o.sel} )
);

/* test/tb_soc.sv */
`timescale 1ns/10ps

module tb_soc;

    typedef struct {
        logic                           write;
        logic [soc_pkg::ADDR_WIDTH-1:0] addr;
        logic [soc_pkg::DATA_WIDTH-1:0] wdata;
        logic [soc_pkg::STRB_WIDTH-1:0] strb;
        logic [soc_pkg::DATA_WIDTH-1:0] exp_rdata;
        soc_pkg::resp_t                 exp_resp;
        int                             exp_lat;  // accept -> rsp_valid, cycles
        int                             hold;     // cycles with rsp_ready low
    } row_t;

    logic                           sys_clock, reset;
    logic                           req_valid, req_ready, req_write;
    logic [soc_pkg::ADDR_WIDTH-1:0] req_addr;
    logic [soc_pkg::DATA_WIDTH-1:0] req_wdata;
    logic [soc_pkg::STRB_WIDTH-1:0] req_wstrb;
    logic                           rsp_valid, rsp_ready;
    logic [soc_pkg::DATA_WIDTH-1:0] rsp_rdata;
    soc_pkg::resp_t                 rsp_resp;
    logic                           irq;

    row_t   rows [$];
    int     errors   = 0;
    int     timeouts = 0;
    integer seed     = 32'h43e5;
    logic [soc_pkg::DATA_WIDTH-1:0] mem_addr [4];
    logic [soc_pkg::DATA_WIDTH-1:0] mem_data [4];

    soc_top uut (
        .sys_clock_i ( sys_clock ),
        .reset_i     ( reset     ),
        .req_valid_i ( req_valid ),
        .req_ready_o ( req_ready ),
        .req_write_i ( req_write ),
        .req_addr_i  ( req_addr  ),
        .req_wdata_i ( req_wdata ),
        .req_wstrb_i ( req_wstrb ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_ready_i ( rsp_ready ),
        .rsp_rdata_o ( rsp_rdata ),
        .rsp_resp_o  ( rsp_resp  ),
        .irq_o       ( irq       )
    );

    initial begin
        sys_clock = 1'b0;
        forever #2 sys_clock = ~sys_clock; // 4 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, input logic [31:0] exp_rdata,
                           input soc_pkg::resp_t exp_resp, input int exp_lat, input int hold);
        row_t r;
        r.write     = wr;
        r.addr      = addr;
        r.wdata     = wdata;
        r.strb      = strb;
        r.exp_rdata = exp_rdata;
        r.exp_resp  = exp_resp;
        r.exp_lat   = exp_lat;
        r.hold      = hold;
        rows.push_back(r);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one host transaction, sampled on falling edges
    ////////////////////////////////////////////////////////////////////////////

    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, input int hold,
                              output logic [31:0] rdata, output soc_pkg::resp_t resp,
                              output int lat);
        int cnt;
        rdata = '0;
        resp  = soc_pkg::RESP_OKAY;
        lat   = -1;
        @(posedge sys_clock);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_wstrb <= strb;
        rsp_ready <= (hold == 0);  // low ahead of rsp_valid for back-pressure
        cnt = 0;
        do begin
            @(negedge sys_clock);
            cnt++;
        end while (!req_ready && cnt < 20);
        if (!req_ready) begin
            timed_out("request was never accepted");
            @(posedge sys_clock);
            req_valid <= 1'b0;
            rsp_ready <= 1'b1;
            return;
        end
        @(posedge sys_clock);  // accept edge
        req_valid <= 1'b0;
        lat = 1;
        @(negedge sys_clock);
        while (!rsp_valid && lat < 20) begin
            lat++;
            @(negedge sys_clock);
        end
        if (!rsp_valid) begin
            timed_out("no response after accept");
            lat = -1;
            rsp_ready <= 1'b1;
            return;
        end
        rdata = rsp_rdata;
        resp  = rsp_resp;
        for (int i = 0; i < hold; i++) begin
            @(negedge sys_clock);
            if (rsp_rdata !== rdata) mismatch("held rdata", rsp_rdata, rdata);
            if (rsp_resp !== resp) mismatch("held resp", 32'(rsp_resp), 32'(resp));
            if (req_ready !== 1'b0) mismatch("req_ready under back-pressure", 32'(req_ready), 0);
        end
        @(posedge sys_clock);
        rsp_ready <= 1'b1;
        cnt = 0;
        do begin
            @(negedge sys_clock);
            cnt++;
        end while (rsp_valid && cnt < 20);
        if (rsp_valid) timed_out("response was never taken");
        else if (req_ready !== 1'b1) mismatch("req_ready after transfer", 32'(req_ready), 1);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0]    rd;
        soc_pkg::resp_t rs;
        int             lt;
        bus_access(1'b1, addr, data, 4'hF, 0, rd, rs, lt);
        if (rs !== soc_pkg::RESP_OKAY) mismatch("register write resp", 32'(rs), 0);
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp, input string what);
        logic [31:0]    rd;
        soc_pkg::resp_t rs;
        int             lt;
        bus_access(1'b0, addr, '0, 4'h0, 0, rd, rs, lt);
        if (rd !== exp) mismatch(what, rd, exp);
    endtask

    task automatic wait_irq(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (irq !== level && cnt < 200) begin
            @(negedge sys_clock);
            cnt++;
        end
        if (irq !== level) timed_out(what);
    endtask

    // poll the pending register until both timer lines show
    task automatic wait_pending(input logic [31:0] exp);
        logic [31:0]    rd;
        soc_pkg::resp_t rs;
        int             lt, tries;
        tries = 0;
        rd    = '0;
        while (rd !== exp && tries < 50) begin
            bus_access(1'b0, soc_pkg::PLIC_BASE + soc_pkg::PLIC_PENDING_OFS, '0, 4'h0, 0,
                       rd, rs, lt);
            tries++;
        end
        if (rd !== exp) timed_out("timer flags never both pending");
    endtask

    task automatic finish_run();
        int chk_fails;
        chk_fails = uut.bus_ctrl_u.handshake_chk.fail_count;
        $display("checks done: %0d errors, %0d assertion failures, %0d timeouts",
                 errors, chk_fails, timeouts);
        if (errors == 0 && chk_fails == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]    got_rdata;
        soc_pkg::resp_t got_resp;
        int             got_lat;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        rsp_ready = 1'b1;
        mem_addr  = '{32'h0000_0000, 32'h0000_0040, 32'h0000_03FC, 32'h0000_0124};
        repeat (16) @(posedge sys_clock);
        reset <= 1'b0;
        @(negedge sys_clock);
        if (req_ready !== 1'b1) mismatch("req_ready after reset", 32'(req_ready), 1);
        if (rsp_valid !== 1'b0) mismatch("rsp_valid after reset", 32'(rsp_valid), 0);
        if (irq !== 1'b0) mismatch("irq_o after reset", 32'(irq), 0);

        // random full words, then read back
        for (int k = 0; k < 4; k++) begin
            mem_data[k] = $random(seed);
            add_row(1'b1, soc_pkg::MEM_BASE + mem_addr[k], mem_data[k], 4'hF, '0,
                    soc_pkg::RESP_OKAY, 2, 0);
        end
        for (int k = 0; k < 4; k++) begin
            add_row(1'b0, soc_pkg::MEM_BASE + mem_addr[k], '0, 4'h0, mem_data[k],
                    soc_pkg::RESP_OKAY, 2, 0);
        end
        // lanes 0 and 2 only
        add_row(1'b1, mem_addr[0], 32'hA5A5_A5A5, 4'b0101, '0, soc_pkg::RESP_OKAY, 2, 0);
        add_row(1'b0, mem_addr[0], '0, 4'h0,
                {mem_data[0][31:24], 8'hA5, mem_data[0][15:8], 8'hA5},
                soc_pkg::RESP_OKAY, 2, 0);
        // unmapped region
        add_row(1'b0, 32'h3000_0000, '0, 4'h0, '0, soc_pkg::RESP_DECERR, 1, 0);
        add_row(1'b1, 32'h3000_0004, 32'hFFFF_FFFF, 4'hF, '0, soc_pkg::RESP_DECERR, 1, 0);
        // stalled response, next one only after it
        add_row(1'b0, mem_addr[1], '0, 4'h0, mem_data[1], soc_pkg::RESP_OKAY, 2, 6);
        add_row(1'b0, mem_addr[2], '0, 4'h0, mem_data[2], soc_pkg::RESP_OKAY, 2, 0);

        foreach (rows[i]) begin
            bus_access(rows[i].write, rows[i].addr, rows[i].wdata, rows[i].strb, rows[i].hold,
                       got_rdata, got_resp, got_lat);
            if (got_rdata !== rows[i].exp_rdata)
                mismatch($sformatf("row %0d rdata", i), got_rdata, rows[i].exp_rdata);
            if (got_resp !== rows[i].exp_resp)
                mismatch($sformatf("row %0d resp", i), 32'(got_resp), 32'(rows[i].exp_resp));
            if (got_lat != rows[i].exp_lat)
                mismatch($sformatf("row %0d latency", i), got_lat, rows[i].exp_lat);
        end

        ////////////////////////////////////////////////////////////////////////
        // timer 0 through the plic
        ////////////////////////////////////////////////////////////////////////

        write_reg(soc_pkg::TIMER_BASE + soc_pkg::TMR0_CMP_OFS, 20);
        write_reg(soc_pkg::PLIC_BASE + soc_pkg::PLIC_ENABLE_OFS, 1 << soc_pkg::IRQ_TIMER0);
        if (irq !== 1'b0) mismatch("irq_o before timer start", 32'(irq), 0);
        write_reg(soc_pkg::TIMER_BASE + soc_pkg::TMR0_CTRL_OFS, 32'h1);
        wait_irq(1'b1, "irq_o never rose for timer 0");
        read_check(soc_pkg::PLIC_BASE + soc_pkg::PLIC_CLAIM_OFS, soc_pkg::IRQ_TIMER0,
                   "claim for timer 0");
        write_reg(soc_pkg::TIMER_BASE + soc_pkg::TMR0_CTRL_OFS, 32'h2); // clear flag, stop
        if (irq !== 1'b0) mismatch("irq_o after flag clear", 32'(irq), 0);

        // both fired, gating and lowest line first
        write_reg(soc_pkg::PLIC_BASE + soc_pkg::PLIC_ENABLE_OFS, 1 << soc_pkg::IRQ_TIMER1);
        write_reg(soc_pkg::TIMER_BASE + soc_pkg::TMR0_CMP_OFS, 6);
        write_reg(soc_pkg::TIMER_BASE + soc_pkg::TMR1_CMP_OFS, 3);
        write_reg(soc_pkg::TIMER_BASE + soc_pkg::TMR0_CTRL_OFS, 32'h1);
        write_reg(soc_pkg::TIMER_BASE + soc_pkg::TMR1_CTRL_OFS, 32'h1);
        wait_pending((1 << soc_pkg::IRQ_TIMER0) | (1 << soc_pkg::IRQ_TIMER1));
        if (irq !== 1'b1) mismatch("irq_o with line 3 enabled", 32'(irq), 1);
        read_check(soc_pkg::PLIC_BASE + soc_pkg::PLIC_CLAIM_OFS, soc_pkg::IRQ_TIMER1,
                   "claim with line 3 only");
        write_reg(soc_pkg::PLIC_BASE + soc_pkg::PLIC_ENABLE_OFS,
                  (1 << soc_pkg::IRQ_TIMER0) | (1 << soc_pkg::IRQ_TIMER1));
        read_check(soc_pkg::PLIC_BASE + soc_pkg::PLIC_CLAIM_OFS, soc_pkg::IRQ_TIMER0,
                   "claim with lines 2 and 3");
        write_reg(soc_pkg::PLIC_BASE + soc_pkg::PLIC_ENABLE_OFS, 32'h0);
        if (irq !== 1'b0) mismatch("irq_o with enables cleared", 32'(irq), 0);
        read_check(soc_pkg::PLIC_BASE + soc_pkg::PLIC_CLAIM_OFS, 32'h0,
                   "claim with enables cleared");

        finish_run();
    end

endmodule : tb_soc

/* files.f */
rtl/soc_pkg.sv
rtl/soc_bus_if.sv
rtl/bus_ctrl.sv
rtl/main_memory.sv
rtl/timer_bank.sv
rtl/plic.sv
rtl/soc_top.sv
test/soc_checker.sv
test/tb_soc.sv

/* Makefile */
# Verilator flow for the soc testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_soc -f files.f -o Vtb_soc

# exit status comes from the search for the pass line
run: compile
	@out="$$(./obj_dir/Vtb_soc +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
